/* verification/fetch_trace.txt */
# Columns: test name, redirect address (hex, 0 = start at reset PC), instructions, back-pressure.
# Each record redirects the fetch stream and expects consecutive PCs from its address.
reset_seq           00000000 12 0
refetch_hits        00000100 12 0
redirect_far        00002040 6  0
alias_a             00003000 4  0
alias_b             00005000 4  0
alias_a_again       00003000 4  0
alias_b_again       00005000 4  0
backpressure        00000100 12 1
bp_misses           00008000 10 1
refill_src          0000a000 4  0
redirect_in_refill  0000c040 8  0
refill_kept         0000a010 4  0
bp_redirect         00000110 8  1

/* files.f */
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
verification/fetch_asserts.sv
verification/fetch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --assert
LINT_FLAGS ?= --lint-only -Wall --timing --assert
PASS_TEXT  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the simulation output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/fetch_tb.sv */
module fetch_tb;

  localparam int              CLK_HALF        = 20;
  localparam logic [31:0]     MEM_KEY         = 32'hfa5c_0000;
  localparam logic [31:0]     BOOT_PC         = 32'h0000_0100;  // First fetch address.
  localparam int              CYCLES_PER_INST = 40;
  localparam int              CYCLE_MARGIN    = 100;

  logic                       clk              = 1'b0;
  logic                       nrst             = 1'b0;
  logic                       i_redirect       = 1'b0;
  logic [fetch_pkg::XLEN-1:0] i_redirect_pc    = '0;
  logic                       i_inst_ready     = 1'b0;
  logic                       i_mem_req_ready  = 1'b0;
  logic                       i_mem_resp_valid = 1'b0;
  logic [fetch_pkg::XLEN-1:0] i_mem_resp_data  = '0;
  logic                       o_inst_valid;
  logic [fetch_pkg::XLEN-1:0] o_inst;
  logic [fetch_pkg::XLEN-1:0] o_inst_pc;
  logic                       o_mem_req_valid;
  logic [fetch_pkg::XLEN-1:0] o_mem_addr;

  integer                     seed        = 32'hfa5c;
  logic                       bp_ready_q  = 1'b0;  // Random ready bit for back-pressure.
  logic                       mem_busy    = 1'b0;
  int                         mem_wait    = 0;
  logic [fetch_pkg::XLEN-1:0] mem_addr_q  = '0;
  int                         cycle_count = 0;
  int                         cycle_limit = 0;

  string                      rec_names[$];
  logic [fetch_pkg::XLEN-1:0] rec_addrs[$];
  int                         rec_counts[$];
  bit                         rec_bp[$];

  always #CLK_HALF clk = ~clk;

  fetch_top dut_i (
    .clk              (clk),
    .nrst             (nrst),
    .i_redirect       (i_redirect),
    .i_redirect_pc    (i_redirect_pc),
    .o_inst_valid     (o_inst_valid),
    .o_inst           (o_inst),
    .o_inst_pc        (o_inst_pc),
    .i_inst_ready     (i_inst_ready),
    .o_mem_req_valid  (o_mem_req_valid),
    .o_mem_addr       (o_mem_addr),
    .i_mem_req_ready  (i_mem_req_ready),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

  // Every word in memory is its own byte address scrambled with a key.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_KEY;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped after a failure.");
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    stop_with_failure($sformatf("[ERROR] %s: %s expected %08h, actual %08h",
                                name, what, expected, actual));
  endtask

  // Memory with one read in flight; ready and delay are random.
  always @(posedge clk) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    bp_ready_q <= rnd[0];
    if (!nrst) begin
      i_mem_req_ready  <= 1'b0;
      i_mem_resp_valid <= 1'b0;
      mem_busy         <= 1'b0;
    end else begin
      i_mem_req_ready  <= rnd[1] | rnd[2];
      i_mem_resp_valid <= 1'b0;
      if (mem_busy) begin
        if (mem_wait == 0) begin
          i_mem_resp_valid <= 1'b1;
          i_mem_resp_data  <= mem_word(mem_addr_q);
          mem_busy         <= 1'b0;
        end else begin
          mem_wait <= mem_wait - 1;
        end
      end else if (o_mem_req_valid && i_mem_req_ready) begin
        mem_busy   <= 1'b1;
        mem_addr_q <= o_mem_addr;
        mem_wait   <= int'(rnd[10:8]) % 6;  // Extra delay of 0 to 5 cycles.
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      stop_with_failure($sformatf("Timeout: the run did not end within %0d cycles.",
                                  cycle_limit));
    end
  end

  task automatic read_trace();
    int                         fd;
    int                         n;
    int                         count;
    int                         bp;
    string                      line;
    string                      name;
    logic [fetch_pkg::XLEN-1:0] addr;
    fd = $fopen("verification/fetch_trace.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the trace file verification/fetch_trace.txt.");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment line.
        n = $sscanf(line, "%s %h %d %d", name, addr, count, bp);
        if (n != 4) begin
          stop_with_failure({"The trace holds a malformed line: ", line});
        end else begin
          rec_names.push_back(name);
          rec_addrs.push_back(addr);
          rec_counts.push_back(count);
          rec_bp.push_back(bp != 0);
        end
      end
      $fclose(fd);
    end
  endtask

  // An address of zero continues from the reset PC without a redirect.
  task automatic run_record(input string name, input logic [31:0] addr,
                            input int count, input bit bp);
    logic [31:0] exp_pc;
    int          got;
    exp_pc = (addr == '0) ? BOOT_PC : addr;
    got    = 0;
    if (addr != '0) begin
      @(posedge clk);
      i_redirect    <= 1'b1;
      i_redirect_pc <= addr;
      @(posedge clk);
      i_redirect    <= 1'b0;
    end
    while (got < count) begin
      i_inst_ready <= bp ? bp_ready_q : 1'b1;
      @(posedge clk);
      if (o_inst_valid && i_inst_ready) begin
        assert (o_inst_pc == exp_pc)
          else report_mismatch(name, "pc", exp_pc, o_inst_pc);
        assert (o_inst == mem_word(exp_pc))
          else report_mismatch(name, "instruction", mem_word(exp_pc), o_inst);
        exp_pc  = exp_pc + 32'd4;
        got++;
      end
    end
    i_inst_ready <= 1'b0;  // Hold the next instruction until the next record.
  endtask

  initial begin
    int total;
    total = 0;
    read_trace();
    foreach (rec_counts[i]) total += rec_counts[i];
    if (rec_names.size() == 0) begin
      stop_with_failure("The trace file holds no test records.");
    end else begin
      cycle_limit = total * CYCLES_PER_INST + CYCLE_MARGIN;
      repeat (2) @(posedge clk);
      nrst <= 1'b1;
      foreach (rec_names[i]) begin
        run_record(rec_names[i], rec_addrs[i], rec_counts[i], rec_bp[i]);
      end
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* verification/fetch_asserts.sv */
module fetch_asserts (
  input logic                       clk,
  input logic                       nrst,
  input logic                       i_redirect,
  input logic                       o_inst_valid,
  input logic [fetch_pkg::XLEN-1:0] o_inst,
  input logic [fetch_pkg::XLEN-1:0] o_inst_pc,
  input logic                       i_inst_ready,
  input logic                       o_mem_req_valid,
  input logic [fetch_pkg::XLEN-1:0] o_mem_addr,
  input logic                       i_mem_req_ready
);

  // Set once a reset edge has been applied, so the first edge is not checked.
  logic reset_seen = 1'b0;

  always @(posedge clk) begin
    if (!nrst) begin
      reset_seen <= 1'b1;
    end
  end

  reset_quiet: assert property (@(posedge clk)
    (!nrst && reset_seen) |-> (!o_inst_valid && !o_mem_req_valid))
    else $error("An output valid was high during reset.");

  // A held instruction only changes when a redirect flushes it.
  hold_stable: assert property (@(posedge clk) disable iff (!nrst)
    (o_inst_valid && !i_inst_ready) |=>
      (i_redirect || (o_inst_valid && $stable(o_inst) && $stable(o_inst_pc))))
    else $error("The instruction changed while it was held by back-pressure.");

  // A memory read keeps its word-aligned address until the memory takes it.
  mem_req_held: assert property (@(posedge clk) disable iff (!nrst)
    (o_mem_req_valid && !i_mem_req_ready) |=>
      (o_mem_req_valid && $stable(o_mem_addr) && (o_mem_addr[1:0] == 2'b00)))
    else $error("The memory read request changed or was misaligned before it was taken.");

endmodule

bind fetch_top fetch_asserts fetch_asserts_i (
  .clk             (clk),
  .nrst            (nrst),
  .i_redirect      (i_redirect),
  .o_inst_valid    (o_inst_valid),
  .o_inst          (o_inst),
  .o_inst_pc       (o_inst_pc),
  .i_inst_ready    (i_inst_ready),
  .o_mem_req_valid (o_mem_req_valid),
  .o_mem_addr      (o_mem_addr),
  .i_mem_req_ready (i_mem_req_ready)
);

/* rtl/fetch_top.sv */
module fetch_top (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       i_redirect,
  input  logic [fetch_pkg::XLEN-1:0] i_redirect_pc,
  output logic                       o_inst_valid,
  output logic [fetch_pkg::XLEN-1:0] o_inst,
  output logic [fetch_pkg::XLEN-1:0] o_inst_pc,
  input  logic                       i_inst_ready,
  output logic                       o_mem_req_valid,
  output logic [fetch_pkg::XLEN-1:0] o_mem_addr,
  input  logic                       i_mem_req_ready,
  input  logic                       i_mem_resp_valid,
  input  logic [fetch_pkg::XLEN-1:0] i_mem_resp_data
);

  logic                       pc_valid;
  logic                       pc_ready;
  logic [fetch_pkg::XLEN-1:0] pc_addr;

  pc_gen pc_gen_i (
    .clk           (clk),
    .nrst          (nrst),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_pc_valid    (pc_valid),
    .o_pc          (pc_addr),
    .i_pc_ready    (pc_ready)
  );

  // The redirect also flushes whatever the fetch stage has in flight.
  fetch_unit fetch_unit_i (
    .clk              (clk),
    .nrst             (nrst),
    .i_pc_valid       (pc_valid),
    .i_pc             (pc_addr),
    .o_pc_ready       (pc_ready),
    .i_flush          (i_redirect),
    .o_inst_valid     (o_inst_valid),
    .o_inst           (o_inst),
    .o_inst_pc        (o_inst_pc),
    .i_inst_ready     (i_inst_ready),
    .o_mem_req_valid  (o_mem_req_valid),
    .o_mem_addr       (o_mem_addr),
    .i_mem_req_ready  (i_mem_req_ready),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       i_pc_valid,
  input  logic [fetch_pkg::XLEN-1:0] i_pc,
  output logic                       o_pc_ready,
  input  logic                       i_flush,
  output logic                       o_inst_valid,
  output logic [fetch_pkg::XLEN-1:0] o_inst,
  output logic [fetch_pkg::XLEN-1:0] o_inst_pc,
  input  logic                       i_inst_ready,
  output logic                       o_mem_req_valid,
  output logic [fetch_pkg::XLEN-1:0] o_mem_addr,
  input  logic                       i_mem_req_ready,
  input  logic                       i_mem_resp_valid,
  input  logic [fetch_pkg::XLEN-1:0] i_mem_resp_data
);

  logic                                                   req_valid_q;
  logic [fetch_pkg::XLEN-1:0]                             req_pc_q;
  logic                                                   cache_valid;
  logic                                                   cache_ready;
  logic                                                   line_valid;
  logic                                                   line_ready;
  logic [fetch_pkg::XLEN-1:0]                             line_addr;
  logic [fetch_pkg::LINE_WORDS-1:0][fetch_pkg::XLEN-1:0] line_data;
  logic                                                   line_match;
  logic                                                   can_accept;

  // Only a line for the request still in flight may reach the back end.
  assign line_match   = req_valid_q && (line_addr == req_pc_q) && !i_flush;
  assign o_inst_valid = line_valid && line_match;
  assign o_inst       = line_data[line_addr[fetch_pkg::OFFSET_W-1 -: fetch_pkg::WORD_IDX_W]];
  assign o_inst_pc    = line_addr;

  // Stale lines are drained at once so the cache can move on.
  assign line_ready = !line_match || i_inst_ready;

  // The address offered during a flush is from the old path and is refused.
  assign can_accept  = !i_flush && (!req_valid_q || (o_inst_valid && i_inst_ready));
  assign cache_valid = i_pc_valid && can_accept;
  assign o_pc_ready  = can_accept && cache_ready;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      req_valid_q <= 1'b0;
    end else if (i_flush) begin
      req_valid_q <= 1'b0;
    end else if (i_pc_valid && o_pc_ready) begin
      req_valid_q <= 1'b1;
    end else if (o_inst_valid && i_inst_ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_pc_valid && o_pc_ready) begin
      req_pc_q <= i_pc;
    end
  end

  icache icache_i (
    .clk              (clk),
    .nrst             (nrst),
    .i_valid          (cache_valid),
    .i_addr           (i_pc),
    .o_ready          (cache_ready),
    .o_valid          (line_valid),
    .o_addr           (line_addr),
    .o_data           (line_data),
    .i_ready          (line_ready),
    .o_mem_req_valid  (o_mem_req_valid),
    .o_mem_addr       (o_mem_addr),
    .i_mem_req_ready  (i_mem_req_ready),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

endmodule

/* rtl/icache.sv */
module icache (
  input  logic                                                  clk,
  input  logic                                                  nrst,
  input  logic                                                  i_valid,
  input  logic [fetch_pkg::XLEN-1:0]                            i_addr,
  output logic                                                  o_ready,
  output logic                                                  o_valid,
  output logic [fetch_pkg::XLEN-1:0]                            o_addr,
  output logic [fetch_pkg::LINE_WORDS-1:0][fetch_pkg::XLEN-1:0] o_data,
  input  logic                                                  i_ready,
  output logic                                                  o_mem_req_valid,
  output logic [fetch_pkg::XLEN-1:0]                            o_mem_addr,
  input  logic                                                  i_mem_req_ready,
  input  logic                                                  i_mem_resp_valid,
  input  logic [fetch_pkg::XLEN-1:0]                            i_mem_resp_data
);

  logic [fetch_pkg::LINES-1:0]                            line_valid_q;
  logic [fetch_pkg::TAG_W-1:0]                            tag_mem [fetch_pkg::LINES];
  logic [fetch_pkg::LINE_WORDS-1:0][fetch_pkg::XLEN-1:0] data_mem [fetch_pkg::LINES];

  fetch_pkg::cache_state_e                                state_q;
  logic                                                   hit_valid_q;
  logic [fetch_pkg::XLEN-1:0]                             addr_q;
  logic [fetch_pkg::LINE_WORDS-1:0][fetch_pkg::XLEN-1:0] line_q;
  logic [fetch_pkg::LINE_WORDS-1:0][fetch_pkg::XLEN-1:0] line_fill;
  logic [fetch_pkg::WORD_IDX_W-1:0]                       word_q;

  logic [fetch_pkg::INDEX_W-1:0] req_index;
  logic [fetch_pkg::INDEX_W-1:0] fill_index;
  logic [fetch_pkg::TAG_W-1:0]   req_tag;
  logic [fetch_pkg::TAG_W-1:0]   fill_tag;
  logic                          accept;
  logic                          hit;
  logic                          fill_word;
  logic                          last_word;

  assign req_index  = i_addr[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
  assign req_tag    = i_addr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];
  assign fill_index = addr_q[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W];
  assign fill_tag   = addr_q[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];

  assign hit = line_valid_q[req_index] && (tag_mem[req_index] == req_tag);

  // A held hit response blocks new lookups until the consumer takes it.
  assign o_ready = (state_q == fetch_pkg::S_IDLE) && (!hit_valid_q || i_ready);
  assign accept  = i_valid && o_ready;

  assign o_valid = hit_valid_q || (state_q == fetch_pkg::S_RESP);
  assign o_addr  = addr_q;
  assign o_data  = line_q;

  // Refill reads go out one word at a time, lowest word first.
  assign o_mem_req_valid = (state_q == fetch_pkg::S_REQ);
  assign o_mem_addr      = {addr_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W], word_q, 2'b00};

  // The memory answers in a cycle after the request handshake.
  assign fill_word = (state_q == fetch_pkg::S_WAIT) && i_mem_resp_valid;
  assign last_word = (word_q == fetch_pkg::LAST_WORD);

  always_comb begin
    line_fill         = line_q;
    line_fill[word_q] = i_mem_resp_data;
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q      <= fetch_pkg::S_IDLE;
      hit_valid_q  <= 1'b0;
      line_valid_q <= '0;
      word_q       <= '0;
    end else begin
      case (state_q)
        fetch_pkg::S_IDLE: begin
          if (accept) begin
            hit_valid_q <= hit;
            if (!hit) begin
              state_q <= fetch_pkg::S_REQ;
              word_q  <= '0;
            end
          end else if (i_ready) begin
            hit_valid_q <= 1'b0;
          end
        end
        fetch_pkg::S_REQ: begin
          if (i_mem_req_ready) begin
            state_q <= fetch_pkg::S_WAIT;
          end
        end
        fetch_pkg::S_WAIT: begin
          if (i_mem_resp_valid) begin
            if (last_word) begin
              state_q                  <= fetch_pkg::S_RESP;
              line_valid_q[fill_index] <= 1'b1;  // Line is complete.
            end else begin
              state_q <= fetch_pkg::S_REQ;
              word_q  <= word_q + 1'b1;
            end
          end
        end
        fetch_pkg::S_RESP: begin
          if (i_ready) begin
            state_q <= fetch_pkg::S_IDLE;
          end
        end
        default: state_q <= fetch_pkg::S_IDLE;
      endcase
    end
  end

  // Arrays and the response line.
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= i_addr;
      line_q <= data_mem[req_index];
    end
    if (fill_word) begin
      line_q <= line_fill;
      if (last_word) begin
        data_mem[fill_index] <= line_fill;
        tag_mem[fill_index]  <= fill_tag;
      end
    end
  end

endmodule

/* rtl/pc_gen.sv */
module pc_gen (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       i_redirect,
  input  logic [fetch_pkg::XLEN-1:0] i_redirect_pc,
  output logic                       o_pc_valid,
  output logic [fetch_pkg::XLEN-1:0] o_pc,
  input  logic                       i_pc_ready
);

  logic                       valid_q;
  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic                       step;

  assign step = valid_q && i_pc_ready;

  // The address is always meaningful once out of reset, so valid only drops
  // during reset itself.
  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_q <= 1'b0;
      pc_q    <= fetch_pkg::RESET_PC;
    end else begin
      valid_q <= 1'b1;
      if (i_redirect) begin
        pc_q <= i_redirect_pc;  // A redirect beats a sequential step.
      end else if (step) begin
        pc_q <= pc_q + fetch_pkg::PC_STEP;
      end
    end
  end

  assign o_pc_valid = valid_q;
  assign o_pc       = pc_q;

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // Data and address width of the core.
  localparam int XLEN = 32;

  // First fetch address after reset.
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

  // Address increment between two sequential instructions.
  localparam logic [XLEN-1:0] PC_STEP = 4;

  // Cache geometry. A line holds LINE_WORDS words of XLEN bits.
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_W   = 4;  // Byte offset within a line.
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = XLEN - INDEX_W - OFFSET_W;
  localparam int LINES      = 2 ** INDEX_W;

  // Word select bits inside a line, above the two byte bits.
  localparam int WORD_IDX_W = OFFSET_W - 2;
  localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(LINE_WORDS - 1);

  // Refill sequence of the instruction cache.
  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_RESP
  } cache_state_e;

endpackage
